//--- files.f
verilog/audio_pkg.sv
verilog/dsp_if.sv
verilog/dsp_mac.sv
verilog/dsp_arbiter.sv
verilog/biquad_sequencer.sv
verilog/biquad_cascade.sv
test/biquad_cascade_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the biquad cascade testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module biquad_cascade_tb \
    -f files.f \
    -o biquad_cascade_sim

result=$(./obj_dir/biquad_cascade_sim)
echo "$result"

if echo "$result" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
fi
exit 1

//--- test/biquad_cascade_tb.sv
// ----------------------------------------------------------------------
// Stereo biquad cascade testbench
// Random stimulus against a per-stage model, with handshake checks
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module biquad_cascade_tb;

    localparam int NUM_STAGES = 2;
    localparam int FRAC_BITS  = 16;
    localparam int TAPS       = 5;
    localparam int SET_W      = TAPS * 18;
    localparam int ONE        = 1 << FRAC_BITS;
    localparam logic [31:0] SEED = 32'hf885_b153;

    // 18-bit signed range
    localparam int SMP_HI = 131071;
    localparam int SMP_LO = -131072;

    // Samples per test
    localparam int N_UNITY   = 8;
    localparam int N_FIR     = 24;
    localparam int N_IIR     = 40;
    localparam int N_CLAMP   = 16;
    localparam int N_BP      = 24;
    localparam int N_RST     = 10;
    localparam int TOTAL_SMP = N_UNITY + N_FIR + N_IIR + N_CLAMP + N_BP + 2 * N_RST;

    logic               clk;
    logic               reset;
    logic [NUM_STAGES*SET_W-1:0] coefs;
    audio_pkg::sample_t smp_in_l;
    audio_pkg::sample_t smp_in_r;
    logic               in_req;
    logic               in_ack;
    audio_pkg::sample_t smp_out_l;
    audio_pkg::sample_t smp_out_r;
    logic               out_req;
    logic               out_ack;

    // b0, b1, b2, a1, a2 per stage, a terms already negated
    int cf [NUM_STAGES][TAPS];
    // Model state x1, x2, y1, y2 per stage and lane
    int st [NUM_STAGES][2][4];
    int exp_l [$];
    int exp_r [$];

    logic [31:0] rng;
    logic [31:0] dly_rng;
    int          errors;
    int          checks;
    int          tests;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    biquad_cascade #(
        .NUM_STAGES (NUM_STAGES),
        .FRAC_BITS  (FRAC_BITS)
    ) biquad_cascade_i (
        .clk       (clk),
        .reset     (reset),
        .coefs     (coefs),
        .smp_in_l  (smp_in_l),
        .smp_in_r  (smp_in_r),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .smp_out_l (smp_out_l),
        .smp_out_r (smp_out_r),
        .out_req   (out_req),
        .out_ack   (out_ack)
    );

    // ----------------------------------------------------------------------
    // Random numbers and reference model
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int rand_span(input int lo, input int span);
        rng = xorshift32(rng);
        return lo + int'(rng % span);
    endfunction

    function automatic int clamp_shift(input longint acc);
        longint s;
        s = acc >>> FRAC_BITS;
        if (s > SMP_HI) return SMP_HI;
        if (s < SMP_LO) return SMP_LO;
        return int'(s);
    endfunction

    // One biquad step with exact accumulation
    function automatic int model_stage(input int k, input int lane, input int x);
        longint acc;
        int     y;
        acc = longint'(cf[k][0]) * x + longint'(cf[k][1]) * st[k][lane][0]
            + longint'(cf[k][2]) * st[k][lane][1] + longint'(cf[k][3]) * st[k][lane][2]
            + longint'(cf[k][4]) * st[k][lane][3];
        y = clamp_shift(acc);
        st[k][lane][1] = st[k][lane][0];
        st[k][lane][0] = x;
        st[k][lane][3] = st[k][lane][2];
        st[k][lane][2] = y;
        return y;
    endfunction

    function automatic int model_cascade(input int lane, input int x);
        int v;
        v = x;
        for (int k = 0; k < NUM_STAGES; k++) begin
            v = model_stage(k, lane, v);
        end
        return v;
    endfunction

    task automatic clear_model();
        for (int k = 0; k < NUM_STAGES; k++) begin
            for (int n = 0; n < 4; n++) begin
                st[k][0][n] = 0;
                st[k][1][n] = 0;
            end
        end
    endtask

    // Kind 0 unity, 1 FIR, 2 stable IIR, 3 gain above one
    task automatic pick_coefs(input int kind);
        logic [NUM_STAGES*SET_W-1:0] v;
        for (int k = 0; k < NUM_STAGES; k++) begin
            for (int t = 0; t < TAPS; t++) begin
                cf[k][t] = (kind == 1 || kind == 2) && t < 3 ? rand_span(-32768, 65536) : 0;
            end
            if (kind == 0) cf[k][0] = ONE;
            if (kind == 3) cf[k][0] = rand_span(ONE + ONE / 2, ONE / 4);
            if (kind == 2) begin
                // |a1| < 0.5 and |a2| < 0.25 keeps the poles inside the unit circle
                cf[k][3] = rand_span(-32768, 65536);
                cf[k][4] = rand_span(-16384, 32768);
            end
            for (int t = 0; t < TAPS; t++) begin
                v[(k * TAPS + t) * 18 +: 18] = 18'(cf[k][t]);
            end
        end
        @(posedge clk);
        coefs <= v;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus and checks
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input int got, input int expv);
        checks++;
        assert (got == expv) else begin
            $display("Error at %0t ns: %s expected %0d got %0d", $time, name, expv, got);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset   <= 1'b1;
        in_req  <= 1'b0;
        out_ack <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Four-phase input handshake for one sample pair
    task automatic offer_sample(input int l, input int r);
        @(posedge clk);
        smp_in_l <= 18'(l);
        smp_in_r <= 18'(r);
        in_req   <= 1'b1;
        do @(posedge clk); while (!in_ack);
        in_req <= 1'b0;
        do @(posedge clk); while (in_ack);
    endtask

    task automatic send_samples(input int n, input int amp);
        int l;
        int r;
        for (int s = 0; s < n; s++) begin
            l = rand_span(-amp, 2 * amp);
            r = rand_span(-amp, 2 * amp);
            exp_l.push_back(model_cascade(0, l));
            exp_r.push_back(model_cascade(1, r));
            offer_sample(l, r);
        end
    endtask

    task automatic take_samples(input int n, input int max_delay);
        for (int s = 0; s < n; s++) begin
            do @(posedge clk); while (!out_req);
            check_value("smp_out_l", int'(smp_out_l), exp_l.pop_front());
            check_value("smp_out_r", int'(smp_out_r), exp_r.pop_front());
            dly_rng = xorshift32(dly_rng);
            repeat (int'(dly_rng % (max_delay + 1))) @(posedge clk);
            out_ack <= 1'b1;
            do @(posedge clk); while (out_req);
            out_ack <= 1'b0;
        end
    endtask

    task automatic run_stream(input int n, input int amp, input int max_delay);
        fork
            send_samples(n, amp);
            take_samples(n, max_delay);
        join
        // A repeated sample shows up as a stray out_req here
        repeat (40) @(posedge clk);
        checks++;
        assert (!out_req) else begin
            $display("Output count wrong: out_req raised after the stream had drained");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("%s: %s", name, errors == err0 ? "ok" : "mismatch");
    endtask

    // Four-phase ordering at both ends
    assert property (@(posedge clk) disable iff (reset) $rose(in_ack) |-> $past(in_req))
    else begin
        $display("Handshake broken: in_ack rose without in_req at %0t ns", $time);
        errors++;
    end
    assert property (@(posedge clk) disable iff (reset) $fell(in_ack) |-> !$past(in_req))
    else begin
        $display("Handshake broken: in_ack fell while in_req was high at %0t ns", $time);
        errors++;
    end
    assert property (@(posedge clk) disable iff (reset) $rose(out_req) |-> !$past(out_ack))
    else begin
        $display("Handshake broken: out_req rose while out_ack was high at %0t ns", $time);
        errors++;
    end
    assert property (@(posedge clk) disable iff (reset) $fell(out_req) |-> $past(out_ack))
    else begin
        $display("Handshake broken: out_req fell without out_ack at %0t ns", $time);
        errors++;
    end
    assert property (@(posedge clk) disable iff (reset) out_req && $past(out_req) |->
                     smp_out_l == $past(smp_out_l) && smp_out_r == $past(smp_out_r))
    else begin
        $display("Output data changed while out_req was high at %0t ns", $time);
        errors++;
    end

    // Watchdog
    initial begin
        #(TOTAL_SMP * 40 * 40);
        $display("Timeout: the cascade stopped making progress");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int err0;
        reset    = 1'b1;
        in_req   = 1'b0;
        out_ack  = 1'b0;
        smp_in_l = '0;
        smp_in_r = '0;
        coefs    = '0;
        rng      = SEED;
        dly_rng  = SEED;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        clear_model();

        err0 = errors;
        pick_coefs(0);
        apply_reset();
        @(posedge clk);
        check_value("in_ack", int'(in_ack), 0);
        check_value("out_req", int'(out_req), 0);
        run_stream(N_UNITY, 131072, 0);
        report_test("Test 1 reset state and unity gain", err0);

        err0 = errors;
        pick_coefs(1);
        run_stream(N_FIR, 65536, 0);
        report_test("Test 2 FIR taps", err0);

        err0 = errors;
        pick_coefs(2);
        run_stream(N_IIR, 32768, 0);
        report_test("Test 3 IIR feedback", err0);

        err0 = errors;
        pick_coefs(3);
        run_stream(N_CLAMP, 131072, 0);
        report_test("Test 4 saturation", err0);

        err0 = errors;
        pick_coefs(2);
        run_stream(N_BP, 32768, 4);
        report_test("Test 5 out_ack back-pressure", err0);

        // Reset lands while a sample is still inside stage 0
        err0 = errors;
        run_stream(N_RST, 32768, 1);
        offer_sample(rand_span(-32768, 65536), rand_span(-32768, 65536));
        repeat (4) @(posedge clk);
        apply_reset();
        clear_model();
        run_stream(N_RST, 32768, 1);
        report_test("Test 6 reset mid-stream", err0);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end
        else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/biquad_cascade.sv
// --------------------------------------------------------------------
// Stereo biquad cascade
// Chained IIR stages sharing one arbitrated multiply slice
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module biquad_cascade #(
    parameter int NUM_STAGES = 2,
    parameter int FRAC_BITS  = 16
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic [NUM_STAGES*audio_pkg::NUM_TAPS*audio_pkg::SAMPLE_W-1:0] coefs,
    input  wire audio_pkg::sample_t smp_in_l,
    input  wire audio_pkg::sample_t smp_in_r,
    input  wire logic in_req,
    output wire logic in_ack,
    output wire audio_pkg::sample_t smp_out_l,
    output wire audio_pkg::sample_t smp_out_r,
    output wire logic out_req,
    input  wire logic out_ack
);

    localparam int SET_W = audio_pkg::NUM_TAPS * audio_pkg::SAMPLE_W;

    // Handshake chain, entry k feeds stage k
    wire audio_pkg::sample_t ch_l [NUM_STAGES+1];
    wire audio_pkg::sample_t ch_r [NUM_STAGES+1];
    wire logic [NUM_STAGES:0] ch_req;
    wire logic [NUM_STAGES:0] ch_ack;

    wire audio_pkg::dsp_op_t mac_op;
    wire audio_pkg::sample_t mac_a_l;
    wire audio_pkg::sample_t mac_b_l;
    wire audio_pkg::sample_t mac_a_r;
    wire audio_pkg::sample_t mac_b_r;
    wire audio_pkg::acc_t    mac_p_l;
    wire audio_pkg::acc_t    mac_p_r;

    assign ch_l[0]            = smp_in_l;
    assign ch_r[0]            = smp_in_r;
    assign ch_req[0]          = in_req;
    assign in_ack             = ch_ack[0];
    assign smp_out_l          = ch_l[NUM_STAGES];
    assign smp_out_r          = ch_r[NUM_STAGES];
    assign out_req            = ch_req[NUM_STAGES];
    assign ch_ack[NUM_STAGES] = out_ack;

    dsp_if dsp_bus [NUM_STAGES] ();

    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        biquad_sequencer #(
            .FRAC_BITS (FRAC_BITS)
        ) biquad_sequencer_i (
            .clk       (clk),
            .reset     (reset),
            .coefs     (coefs[k*SET_W +: SET_W]),
            .smp_in_l  (ch_l[k]),
            .smp_in_r  (ch_r[k]),
            .in_req    (ch_req[k]),
            .in_ack    (ch_ack[k]),
            .smp_out_l (ch_l[k+1]),
            .smp_out_r (ch_r[k+1]),
            .out_req   (ch_req[k+1]),
            .out_ack   (ch_ack[k+1]),
            .dsp       (dsp_bus[k])
        );
    end

    dsp_arbiter #(
        .NUM_STAGES (NUM_STAGES)
    ) dsp_arbiter_i (
        .clk     (clk),
        .reset   (reset),
        .clients (dsp_bus),
        .op      (mac_op),
        .a_l     (mac_a_l),
        .b_l     (mac_b_l),
        .a_r     (mac_a_r),
        .b_r     (mac_b_r),
        .p_l     (mac_p_l),
        .p_r     (mac_p_r)
    );

    dsp_mac dsp_mac_i (
        .clk   (clk),
        .reset (reset),
        .op    (mac_op),
        .a_l   (mac_a_l),
        .b_l   (mac_b_l),
        .a_r   (mac_a_r),
        .b_r   (mac_b_r),
        .p_l   (mac_p_l),
        .p_r   (mac_p_r)
    );

endmodule

`default_nettype wire

//--- verilog/biquad_sequencer.sv
// --------------------------------------------------------------------
// Biquad stage sequencer
// Microcoded control of one stereo IIR stage on the shared slice
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module biquad_sequencer #(
    parameter int FRAC_BITS = 16
) (
    input  wire logic                                     clk,
    input  wire logic                                     reset,
    input  wire audio_pkg::coef_t [audio_pkg::NUM_TAPS-1:0] coefs,
    input  wire audio_pkg::sample_t                       smp_in_l,
    input  wire audio_pkg::sample_t                       smp_in_r,
    input  wire logic                                     in_req,
    output logic                                          in_ack,
    output audio_pkg::sample_t                            smp_out_l,
    output audio_pkg::sample_t                            smp_out_r,
    output logic                                          out_req,
    input  wire logic                                     out_ack,
    dsp_if.client                                         dsp
);

    // --------------------------------------------------------------------
    // Task table
    // --------------------------------------------------------------------
    localparam logic [6:0] T_WAIT_IN  = 7'h01;
    localparam logic [6:0] T_PUSH_X   = 7'h02;
    localparam logic [6:0] T_MUL_IN   = 7'h04;
    localparam logic [6:0] T_MAC_XY   = 7'h08;
    localparam logic [6:0] T_INC_I    = 7'h10;
    localparam logic [6:0] T_TAKE_RES = 7'h20;
    localparam logic [6:0] T_JP_0     = 7'h40;

    localparam logic [2:0] LAST_I = 3'(audio_pkg::NUM_TAPS - 1);

    logic [2:0] pc;
    logic [6:0] tasks;
    logic [6:0] run;
    logic [2:0] i_reg;
    logic       accept;
    logic       hold_gnt;
    logic       stall;

    audio_pkg::sample_t smp_l_q;
    audio_pkg::sample_t smp_r_q;
    audio_pkg::sample_t res_l;
    audio_pkg::sample_t res_r;

    // Index 0..2 hold x0..x2, 3..4 hold y1..y2, matching coefs
    audio_pkg::sample_t xy_l [audio_pkg::NUM_TAPS];
    audio_pkg::sample_t xy_r [audio_pkg::NUM_TAPS];

    always_comb begin
        case (pc)
            3'd0:    tasks = T_WAIT_IN;
            3'd1:    tasks = T_PUSH_X | T_MUL_IN | T_INC_I;
            3'd2:    tasks = T_MAC_XY | T_INC_I;
            3'd3:    tasks = '0;  // last product in flight
            3'd4:    tasks = T_TAKE_RES | T_JP_0;
            default: tasks = T_JP_0;
        endcase
    end

    // New input only once the previous output handshake is done
    assign accept   = (tasks & T_WAIT_IN) != '0 && in_req && !in_ack &&
                      !out_req && !out_ack;
    assign hold_gnt = (tasks & T_MUL_IN) != '0 && !dsp.gnt;
    assign run      = hold_gnt ? '0 : tasks;
    assign stall    = ((tasks & T_WAIT_IN) != '0 && !accept) || hold_gnt ||
                      ((tasks & T_MAC_XY) != '0 && i_reg != LAST_I);

    // PC and index register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= '0;
            i_reg <= '0;
        end
        else begin
            if ((run & T_JP_0) != '0) begin
                pc <= '0;
            end
            else if (!stall) begin
                pc <= pc + 3'd1;
            end

            if ((run & T_MAC_XY) != '0 && i_reg == LAST_I) begin
                i_reg <= '0;
            end
            else if ((run & T_INC_I) != '0) begin
                i_reg <= i_reg + 3'd1;
            end
        end
    end

    // --------------------------------------------------------------------
    // Handshakes and slice request
    // --------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_ack  <= 1'b0;
            out_req <= 1'b0;
            dsp.req <= 1'b0;
        end
        else begin
            if (accept) begin
                in_ack <= 1'b1;
            end
            else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end

            if ((run & T_TAKE_RES) != '0) begin
                out_req <= 1'b1;
            end
            else if (out_req && out_ack) begin
                out_req <= 1'b0;
            end

            // Held until the last product has been read
            if (accept) begin
                dsp.req <= 1'b1;
            end
            else if ((run & T_TAKE_RES) != '0) begin
                dsp.req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            smp_l_q <= smp_in_l;
            smp_r_q <= smp_in_r;
        end
    end

    // --------------------------------------------------------------------
    // Slice operands
    // --------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dsp.op <= audio_pkg::OP_NOP;
        end
        else if ((run & T_MUL_IN) != '0) begin
            dsp.op <= audio_pkg::OP_MUL;
        end
        else if ((run & T_MAC_XY) != '0) begin
            dsp.op <= audio_pkg::OP_MAC;
        end
        else begin
            dsp.op <= audio_pkg::OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        dsp.a_l <= coefs[i_reg];
        dsp.a_r <= coefs[i_reg];
        dsp.b_l <= ((run & T_MUL_IN) != '0) ? smp_l_q : xy_l[i_reg];
        dsp.b_r <= ((run & T_MUL_IN) != '0) ? smp_r_q : xy_r[i_reg];
    end

    // Scale back to 18 bits and clamp
    function automatic audio_pkg::sample_t sat(input audio_pkg::acc_t p);
        audio_pkg::acc_t s;
        s = p >>> FRAC_BITS;
        if (s > audio_pkg::SMP_MAX) begin
            return audio_pkg::sample_t'(audio_pkg::SMP_MAX);
        end
        if (s < audio_pkg::SMP_MIN) begin
            return audio_pkg::sample_t'(audio_pkg::SMP_MIN);
        end
        return audio_pkg::sample_t'(s);
    endfunction

    assign res_l = sat(dsp.p_l);
    assign res_r = sat(dsp.p_r);

    // --------------------------------------------------------------------
    // Delay lines and result
    // --------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int n = 0; n < audio_pkg::NUM_TAPS; n++) begin
                xy_l[n] <= '0;
                xy_r[n] <= '0;
            end
        end
        else if ((run & T_PUSH_X) != '0) begin
            xy_l[0] <= smp_l_q;
            xy_l[1] <= xy_l[0];
            xy_l[2] <= xy_l[1];
            xy_r[0] <= smp_r_q;
            xy_r[1] <= xy_r[0];
            xy_r[2] <= xy_r[1];
        end
        else if ((run & T_TAKE_RES) != '0) begin
            // Clamped value is the feedback term
            xy_l[3] <= res_l;
            xy_l[4] <= xy_l[3];
            xy_r[3] <= res_r;
            xy_r[4] <= xy_r[3];
        end
    end

    always_ff @(posedge clk) begin
        if ((run & T_TAKE_RES) != '0) begin
            smp_out_l <= res_l;
            smp_out_r <= res_r;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_arbiter.sv
// --------------------------------------------------------------------
// Round-robin arbiter for the shared multiply slice
// Routes the owning stage's operands and returns products to all
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dsp_arbiter #(
    parameter int NUM_STAGES = 2
) (
    input  wire logic        clk,
    input  wire logic        reset,
    dsp_if.slice             clients [NUM_STAGES],
    output audio_pkg::dsp_op_t op,
    output audio_pkg::sample_t a_l,
    output audio_pkg::sample_t b_l,
    output audio_pkg::sample_t a_r,
    output audio_pkg::sample_t b_r,
    input  wire audio_pkg::acc_t p_l,
    input  wire audio_pkg::acc_t p_r
);

    localparam int IDX_W = (NUM_STAGES > 1) ? $clog2(NUM_STAGES) : 1;

    logic [NUM_STAGES-1:0] req_v;
    audio_pkg::dsp_op_t    op_v  [NUM_STAGES];
    audio_pkg::sample_t    a_l_v [NUM_STAGES];
    audio_pkg::sample_t    b_l_v [NUM_STAGES];
    audio_pkg::sample_t    a_r_v [NUM_STAGES];
    audio_pkg::sample_t    b_r_v [NUM_STAGES];

    logic             owner_vld;
    logic [IDX_W-1:0] owner;
    logic [IDX_W-1:0] rr_ptr;
    logic             next_vld;
    logic [IDX_W-1:0] next_idx;

    // Flatten the client buses so the owner can index them
    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_client
        assign req_v[k]       = clients[k].req;
        assign op_v[k]        = clients[k].op;
        assign a_l_v[k]       = clients[k].a_l;
        assign b_l_v[k]       = clients[k].b_l;
        assign a_r_v[k]       = clients[k].a_r;
        assign b_r_v[k]       = clients[k].b_r;
        assign clients[k].gnt = owner_vld && (owner == IDX_W'(k));
        assign clients[k].p_l = p_l;
        assign clients[k].p_r = p_r;
    end

    // First requester at or after the round-robin pointer
    always_comb begin : pick
        int idx;
        next_vld = 1'b0;
        next_idx = '0;
        for (int off = NUM_STAGES - 1; off >= 0; off--) begin
            idx = (int'(rr_ptr) + off) % NUM_STAGES;
            if (req_v[idx]) begin
                next_vld = 1'b1;
                next_idx = IDX_W'(idx);
            end
        end
    end

    // Owner is released one cycle after its req falls
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owner_vld <= 1'b0;
            owner     <= '0;
            rr_ptr    <= '0;
        end
        else if (owner_vld) begin
            if (!req_v[owner]) begin
                owner_vld <= 1'b0;
                rr_ptr    <= (owner == IDX_W'(NUM_STAGES - 1)) ? '0 : owner + 1'b1;
            end
        end
        else if (next_vld) begin
            owner_vld <= 1'b1;
            owner     <= next_idx;
        end
    end

    // Slice sees NOP when nobody owns it
    assign op  = owner_vld ? op_v[owner] : audio_pkg::OP_NOP;
    assign a_l = a_l_v[owner];
    assign b_l = b_l_v[owner];
    assign a_r = a_r_v[owner];
    assign b_r = b_r_v[owner];

endmodule

`default_nettype wire

//--- verilog/dsp_mac.sv
// --------------------------------------------------------------------
// Dual-lane multiply-accumulate slice
// Registered 18x18 products with a 48-bit accumulate or load per lane
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dsp_mac (
    input  wire audio_pkg::dsp_op_t op,
    input  wire audio_pkg::sample_t a_l,
    input  wire audio_pkg::sample_t b_l,
    input  wire audio_pkg::sample_t a_r,
    input  wire audio_pkg::sample_t b_r,
    input  wire logic               clk,
    input  wire logic               reset,
    output audio_pkg::acc_t         p_l,
    output audio_pkg::acc_t         p_r
);

    // Next accumulator value for one lane
    function automatic audio_pkg::acc_t lane_next(
        input audio_pkg::dsp_op_t lane_op,
        input audio_pkg::sample_t a,
        input audio_pkg::sample_t b,
        input audio_pkg::acc_t    p
    );
        audio_pkg::acc_t prod;
        prod = audio_pkg::acc_t'(a) * audio_pkg::acc_t'(b);
        case (lane_op)
            audio_pkg::OP_MUL: return prod;
            audio_pkg::OP_MAC: return p + prod;
            default:           return p;
        endcase
    endfunction

    // Both lanes share the opcode
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p_l <= '0;
            p_r <= '0;
        end
        else begin
            p_l <= lane_next(op, a_l, b_l, p_l);
            p_r <= lane_next(op, a_r, b_r, p_r);
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_if.sv
// --------------------------------------------------------------------
// Multiply slice bus for one client
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface dsp_if;

    // Client side
    audio_pkg::dsp_op_t op;
    audio_pkg::sample_t a_l;
    audio_pkg::sample_t b_l;
    audio_pkg::sample_t a_r;
    audio_pkg::sample_t b_r;
    logic               req;

    // Arbiter and slice side
    logic               gnt;
    audio_pkg::acc_t    p_l;
    audio_pkg::acc_t    p_r;

    modport client (
        output op, a_l, b_l, a_r, b_r, req,
        input  gnt, p_l, p_r
    );

    modport slice (
        input  op, a_l, b_l, a_r, b_r, req,
        output gnt, p_l, p_r
    );

endinterface

`default_nettype wire

//--- verilog/audio_pkg.sv
// --------------------------------------------------------------------
// Audio filter package
// Sample, coefficient and accumulator types plus the slice opcodes
// --------------------------------------------------------------------
`default_nettype none

package audio_pkg;

    // Widths
    parameter int SAMPLE_W = 18;
    parameter int ACC_W    = 48;

    // Coefficients per biquad, ordered b0, b1, b2, a1, a2
    parameter int NUM_TAPS = 5;

    // Saturation limits of an 18-bit signed sample
    parameter int SMP_MAX = 2 ** (SAMPLE_W - 1) - 1;
    parameter int SMP_MIN = -(2 ** (SAMPLE_W - 1));

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // a1 and a2 are stored negated so every term is summed
    typedef logic signed [SAMPLE_W-1:0] coef_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    // Slice opcodes
    typedef enum logic [1:0] {
        OP_NOP = 2'd0,  // hold accumulator
        OP_MUL = 2'd1,  // load product
        OP_MAC = 2'd2   // add product to accumulator
    } dsp_op_t;

endpackage

`default_nettype wire
